//--- src/sampler_pkg.sv
// Private-key sampler shared sizes and the candidate word view
package sampler_pkg;

    // ------------------------------------------------------------------------
    // Word geometry
    // ------------------------------------------------------------------------
    // One memory word, one digest word
    localparam int WORD_BITS    = 32;
    // Bit index inside a word
    localparam int BIT_SEL_BITS = 5;

    // ------------------------------------------------------------------------
    // Hash message and digest
    // ------------------------------------------------------------------------
    localparam int SEED_BITS   = 256;
    localparam int STATE_BITS  = 1600;
    // Rate part of the state, taken from the top
    localparam int DIGEST_BITS = 1088;

    localparam int DIGEST_WORDS    = DIGEST_BITS / WORD_BITS;
    localparam int DIGEST_IDX_BITS = 6;

    // Split view: memory word select above, bit select below
    typedef struct packed {
        logic [WORD_BITS-BIT_SEL_BITS-1:0] word_sel;
        logic [BIT_SEL_BITS-1:0]           bit_sel;
    } sample_split_t;

    // One random word from the digest.
    // The raw view gives the candidate position, the split view
    // gives the memory address and the bit within the word.
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        sample_split_t        split;
    } sample_word_u;

endpackage

//--- src/sampler_ctrl.sv
// Sequencing FSM for hashing, h0 and h1 sampling and completion
`timescale 1ns/1ps

module sampler_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic enable,
    input  logic keccak_done,
    input  logic weight_full,
    input  logic last_word,
    output logic done,
    output logic keccak_enable,
    output logic keccak_init,
    output logic word_clear,
    output logic word_advance,
    output logic weight_clear,
    output logic poly_sel,
    output logic read_phase,
    output logic write_phase
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ABSORB,
        S_SQUEEZE,
        S_HASH_WAIT,
        S_READ,
        S_WRITE,
        S_SWITCH,
        S_DONE
    } state_t;

    state_t state;
    state_t state_next;

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Low while filling h0, high for h1
    always_ff @(posedge clk) begin
        if (!resetn) begin
            poly_sel <= 1'b0;
        end else if (state == S_SWITCH) begin
            poly_sel <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (enable) begin
                    state_next = S_ABSORB;
                end
            end
            S_ABSORB: begin
                state_next = S_HASH_WAIT;
            end
            S_SQUEEZE: begin
                state_next = S_HASH_WAIT;
            end
            S_HASH_WAIT: begin
                if (keccak_done) begin
                    state_next = S_READ;
                end
            end
            S_READ: begin
                // Full weight hands h0 over to h1 and ends h1
                if (weight_full) begin
                    state_next = poly_sel ? S_DONE : S_SWITCH;
                end else begin
                    state_next = S_WRITE;
                end
            end
            S_WRITE: begin
                state_next = last_word ? S_SQUEEZE : S_READ;
            end
            S_SWITCH: begin
                state_next = S_READ;
            end
            S_DONE: begin
                state_next = S_DONE;
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------
    always_comb begin
        done          = 1'b0;
        keccak_enable = 1'b0;
        keccak_init   = 1'b0;
        word_clear    = 1'b0;
        word_advance  = 1'b0;
        weight_clear  = 1'b0;
        read_phase    = 1'b0;
        write_phase   = 1'b0;
        case (state)
            S_ABSORB: begin
                keccak_enable = 1'b1;
                keccak_init   = 1'b1;
                word_clear    = 1'b1;
                weight_clear  = 1'b1;
            end
            S_SQUEEZE: begin
                keccak_enable = 1'b1;
            end
            S_READ: begin
                read_phase = 1'b1;
            end
            S_WRITE: begin
                read_phase  = 1'b1;
                write_phase = 1'b1;
                // Last word restarts the index for the next block
                word_clear   = last_word;
                word_advance = ~last_word;
            end
            S_SWITCH: begin
                weight_clear = 1'b1;
            end
            S_DONE: begin
                done = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Keccak answers only while the controller waits for a block
    a_done_in_hash_wait: assert property (
        @(posedge clk) disable iff (!resetn)
        keccak_done |-> state == S_HASH_WAIT
    ) else $error("keccak_done outside the hash wait state");

endmodule

//--- src/digest_word_select.sv
// Digest word index and byte-reordering multiplexer for candidate words
`timescale 1ns/1ps

module digest_word_select import sampler_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [STATE_BITS-1:0] keccak_out,
    input  logic                  word_clear,
    input  logic                  word_advance,
    output sample_word_u          cand_word,
    output logic                  last_word
);

    localparam int BYTES_PER_WORD = WORD_BITS / 8;

    logic [DIGEST_BITS-1:0]     digest;
    logic [WORD_BITS-1:0]       digest_word [DIGEST_WORDS];
    logic [DIGEST_IDX_BITS-1:0] word_idx;

    // Digest is the top of the state, byte 0 at the MSB
    assign digest = keccak_out[STATE_BITS-1 -: DIGEST_BITS];

    // ------------------------------------------------------------------------
    // Byte reordering
    // ------------------------------------------------------------------------
    // Word k takes digest bytes 4k..4k+3 with byte 4k as its low byte
    for (genvar k = 0; k < DIGEST_WORDS; k++) begin : g_word
        for (genvar b = 0; b < BYTES_PER_WORD; b++) begin : g_byte
            assign digest_word[k][8*b +: 8] =
                digest[DIGEST_BITS-1-8*(BYTES_PER_WORD*k+b) -: 8];
        end
    end

    always_comb begin
        cand_word.raw = '0;
        if (word_idx < DIGEST_IDX_BITS'(DIGEST_WORDS)) begin
            cand_word.raw = digest_word[word_idx];
        end
    end

    assign last_word = (word_idx == DIGEST_IDX_BITS'(DIGEST_WORDS - 1));

    // ------------------------------------------------------------------------
    // Word index
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            word_idx <= '0;
        end else if (word_clear) begin
            word_idx <= '0;
        end else if (word_advance) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    // Controller restarts the index instead of stepping past word 33
    a_idx_in_range: assert property (
        @(posedge clk) disable iff (!resetn)
        word_idx <= DIGEST_IDX_BITS'(DIGEST_WORDS - 1)
    ) else $error("digest word index beyond last word");

endmodule

//--- src/weight_insert.sv
// Candidate masking, duplicate rejection, memory read-modify-write and weight count
`timescale 1ns/1ps

module weight_insert import sampler_pkg::*; #(
    parameter int R_BITS = 12323,
    parameter int WEIGHT = 71
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  sample_word_u         cand_word,
    input  logic                 poly_sel,
    input  logic                 read_phase,
    input  logic                 write_phase,
    input  logic                 weight_clear,
    input  logic [WORD_BITS-1:0] h0_din,
    input  logic [WORD_BITS-1:0] h1_din,
    output logic                 weight_full,
    output logic                 h0_rden,
    output logic                 h1_rden,
    output logic                 h0_wren,
    output logic                 h1_wren,
    output logic [$clog2(R_BITS)-BIT_SEL_BITS-1:0] h_addr,
    output logic [WORD_BITS-1:0] h_dout,
    output logic                 h0_compact_wren,
    output logic                 h1_compact_wren,
    output logic [$clog2(WEIGHT+1)-1:0] h_compact_addr,
    output logic [WORD_BITS-1:0] h_compact_dout
);

    localparam int POS_BITS  = $clog2(R_BITS);
    localparam int ADDR_BITS = POS_BITS - BIT_SEL_BITS;
    localparam int CNT_BITS  = $clog2(WEIGHT + 1);

    logic [POS_BITS-1:0]     position;
    logic                    pos_valid;
    logic [BIT_SEL_BITS-1:0] bit_sel;
    logic [WORD_BITS-1:0]    bit_mask;
    logic [WORD_BITS-1:0]    rd_word;
    logic                    bit_was_set;
    logic                    word_write;
    logic                    new_bit;
    logic [CNT_BITS-1:0]     weight_cnt;

    // ------------------------------------------------------------------------
    // Candidate decode
    // ------------------------------------------------------------------------
    assign position  = cand_word.raw[POS_BITS-1:0];
    // Positions at or above R_BITS are rejected
    assign pos_valid = ({1'b0, position} < (POS_BITS+1)'(R_BITS));

    assign h_addr  = cand_word.split.word_sel[ADDR_BITS-1:0];
    assign bit_sel = cand_word.split.bit_sel;

    // One-hot bit within the word
    assign bit_mask = WORD_BITS'(1) << bit_sel;

    // ------------------------------------------------------------------------
    // Read-modify-write
    // ------------------------------------------------------------------------
    assign h0_rden = read_phase & ~poly_sel;
    assign h1_rden = read_phase &  poly_sel;

    assign rd_word     = poly_sel ? h1_din : h0_din;
    assign bit_was_set = |(rd_word & bit_mask);

    // Already set bit leaves the word unchanged
    assign h_dout = rd_word | bit_mask;

    assign word_write = write_phase & pos_valid;
    assign h0_wren    = word_write & ~poly_sel;
    assign h1_wren    = word_write &  poly_sel;

    // Duplicates give no compact entry and no weight step
    assign new_bit         = word_write & ~bit_was_set;
    assign h0_compact_wren = new_bit & ~poly_sel;
    assign h1_compact_wren = new_bit &  poly_sel;
    assign h_compact_addr  = weight_cnt;
    assign h_compact_dout  = {{(WORD_BITS-POS_BITS){1'b0}}, position};

    // ------------------------------------------------------------------------
    // Weight counter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            weight_cnt <= '0;
        end else if (weight_clear) begin
            weight_cnt <= '0;
        end else if (new_bit) begin
            weight_cnt <= weight_cnt + 1'b1;
        end
    end

    assign weight_full = (weight_cnt == CNT_BITS'(WEIGHT));

    // Compact write follows a read of that polynomial at the same word address
    a_compact_after_read: assert property (
        @(posedge clk) disable iff (!resetn)
        (h0_compact_wren || h1_compact_wren) |->
            $stable(h_addr) && (h0_compact_wren ? $past(h0_rden) : $past(h1_rden))
    ) else $error("compact write without a read of the same word one cycle before");

endmodule

//--- src/privkey_sampler.sv
// Private-key sampler top level with hash message formatting
`timescale 1ns/1ps

module privkey_sampler import sampler_pkg::*; #(
    parameter int R_BITS = 12323,
    parameter int WEIGHT = 71
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  enable,
    output logic                  done,
    // Keccak core
    input  logic [SEED_BITS-1:0]  seed,
    output logic                  keccak_enable,
    output logic                  keccak_init,
    input  logic                  keccak_done,
    output logic [STATE_BITS-1:0] keccak_m,
    input  logic [STATE_BITS-1:0] keccak_out,
    // Word memories
    output logic                  h0_rden,
    output logic                  h1_rden,
    output logic                  h0_wren,
    output logic                  h1_wren,
    output logic [$clog2(R_BITS)-BIT_SEL_BITS-1:0] h_addr,
    output logic [WORD_BITS-1:0]  h_dout,
    input  logic [WORD_BITS-1:0]  h0_din,
    input  logic [WORD_BITS-1:0]  h1_din,
    // Compact index memories
    output logic                  h0_compact_wren,
    output logic                  h1_compact_wren,
    output logic [$clog2(WEIGHT+1)-1:0] h_compact_addr,
    output logic [WORD_BITS-1:0]  h_compact_dout
);

    sample_word_u cand_word;
    logic         last_word;
    logic         word_clear;
    logic         word_advance;
    logic         weight_clear;
    logic         weight_full;
    logic         poly_sel;
    logic         read_phase;
    logic         write_phase;

    // ------------------------------------------------------------------------
    // Hash message
    // ------------------------------------------------------------------------
    // Seed bytes go in reversed, MSB byte first at bit 0
    for (genvar i = 0; i < SEED_BITS / 8; i++) begin : g_seed_byte
        assign keccak_m[8*i +: 8] = seed[SEED_BITS-1-8*i -: 8];
    end

    // Domain bits after the seed, final rate bit, zero capacity
    assign keccak_m[SEED_BITS+4:SEED_BITS]     = 5'b11111;
    assign keccak_m[DIGEST_BITS-2:SEED_BITS+5] = '0;
    assign keccak_m[DIGEST_BITS-1]             = 1'b1;
    assign keccak_m[STATE_BITS-1:DIGEST_BITS]  = '0;

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------
    sampler_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .enable       (enable),
        .keccak_done  (keccak_done),
        .weight_full  (weight_full),
        .last_word    (last_word),
        .done         (done),
        .keccak_enable(keccak_enable),
        .keccak_init  (keccak_init),
        .word_clear   (word_clear),
        .word_advance (word_advance),
        .weight_clear (weight_clear),
        .poly_sel     (poly_sel),
        .read_phase   (read_phase),
        .write_phase  (write_phase)
    );

    digest_word_select u_word_select (
        .clk         (clk),
        .resetn      (resetn),
        .keccak_out  (keccak_out),
        .word_clear  (word_clear),
        .word_advance(word_advance),
        .cand_word   (cand_word),
        .last_word   (last_word)
    );

    weight_insert #(
        .R_BITS(R_BITS),
        .WEIGHT(WEIGHT)
    ) u_insert (
        .clk            (clk),
        .resetn         (resetn),
        .cand_word      (cand_word),
        .poly_sel       (poly_sel),
        .read_phase     (read_phase),
        .write_phase    (write_phase),
        .weight_clear   (weight_clear),
        .h0_din         (h0_din),
        .h1_din         (h1_din),
        .weight_full    (weight_full),
        .h0_rden        (h0_rden),
        .h1_rden        (h1_rden),
        .h0_wren        (h0_wren),
        .h1_wren        (h1_wren),
        .h_addr         (h_addr),
        .h_dout         (h_dout),
        .h0_compact_wren(h0_compact_wren),
        .h1_compact_wren(h1_compact_wren),
        .h_compact_addr (h_compact_addr),
        .h_compact_dout (h_compact_dout)
    );

endmodule

//--- verification/sampler_env_models.sv
// Keccak stub plus h0/h1 word and compact memory models with write checks
`timescale 1ns/1ps

module sampler_env_models import sampler_pkg::*; #(
    parameter int R_BITS    = 587,
    parameter int WEIGHT    = 10,
    parameter int RAND_SEED = 32'hce14
) (
    input  logic                  clk,
    input  logic                  keccak_enable,
    output logic                  keccak_done,
    output logic [STATE_BITS-1:0] keccak_out,
    input  logic                  h0_rden,
    input  logic                  h1_rden,
    input  logic                  h0_wren,
    input  logic                  h1_wren,
    input  logic [$clog2(R_BITS)-BIT_SEL_BITS-1:0] h_addr,
    input  logic [WORD_BITS-1:0]  h_dout,
    output logic [WORD_BITS-1:0]  h0_din,
    output logic [WORD_BITS-1:0]  h1_din,
    input  logic                  h0_compact_wren,
    input  logic                  h1_compact_wren,
    input  logic [$clog2(WEIGHT+1)-1:0] h_compact_addr,
    input  logic [WORD_BITS-1:0]  h_compact_dout,
    output logic                  check_error
);

    localparam int MEM_WORDS = 2 ** ($clog2(R_BITS) - BIT_SEL_BITS);
    localparam int CMP_WORDS = 2 ** $clog2(WEIGHT + 1);

    logic [WORD_BITS-1:0]   h0_mem [MEM_WORDS];
    logic [WORD_BITS-1:0]   h1_mem [MEM_WORDS];
    logic [WORD_BITS-1:0]   h0_compact [CMP_WORDS];
    logic [WORD_BITS-1:0]   h1_compact [CMP_WORDS];
    logic [DIGEST_BITS-1:0] digest_log [$];
    int                     seed = RAND_SEED;

    initial begin
        keccak_done = 1'b0;
        keccak_out  = '0;
        h0_din      = '0;
        h1_din      = '0;
        check_error = 1'b0;
        foreach (h0_mem[i]) begin
            h0_mem[i] = '0;
            h1_mem[i] = '0;
        end
        foreach (h0_compact[i]) begin
            h0_compact[i] = '0;
            h1_compact[i] = '0;
        end
    end

    task automatic write_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        check_error = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Keccak stub
    // ------------------------------------------------------------------------
    // Each strobe gets a fresh random state after 5 to 30 cycles
    always begin : keccak_stub
        int                    wait_cycles;
        int                    i;
        logic [STATE_BITS-1:0] state;
        @(posedge clk);
        if (keccak_enable) begin
            wait_cycles = 5 + {$random(seed)} % 26;
            for (i = 0; i < STATE_BITS / 32; i++) begin
                state[32*i +: 32] = $random(seed);
            end
            repeat (wait_cycles - 1) @(posedge clk);
            keccak_out  <= state;
            keccak_done <= 1'b1;
            digest_log.push_back(state[STATE_BITS-1 -: DIGEST_BITS]);
            @(posedge clk);
            keccak_done <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Word and compact memories, one cycle read latency
    // ------------------------------------------------------------------------
    always @(posedge clk) begin : mem_model
        logic [WORD_BITS-1:0] old_word;
        logic [WORD_BITS-1:0] bit_mask;
        old_word = h1_wren ? h1_mem[h_addr] : h0_mem[h_addr];
        bit_mask = WORD_BITS'(1) << h_compact_dout[BIT_SEL_BITS-1:0];
        if (h0_wren || h1_wren) begin
            assert (h_dout == (old_word | bit_mask))
                else write_error("word write is not the old word with the position bit set");
            assert ((h0_compact_wren || h1_compact_wren) == ((old_word & bit_mask) == '0))
                else write_error("compact write does not follow the old state of the bit");
            assert (32'(h_addr) == h_compact_dout / 32)
                else write_error($sformatf("word address %0d for position %0d",
                                           h_addr, h_compact_dout));
        end
        if (h0_compact_wren || h1_compact_wren) begin
            assert (h0_compact_wren ? h0_wren : h1_wren)
                else write_error("compact write without a word write to the same polynomial");
        end
        if (h0_rden) h0_din <= h0_mem[h_addr];
        if (h1_rden) h1_din <= h1_mem[h_addr];
        if (h0_wren) h0_mem[h_addr] <= h_dout;
        if (h1_wren) h1_mem[h_addr] <= h_dout;
        if (h0_compact_wren) h0_compact[h_compact_addr] <= h_compact_dout;
        if (h1_compact_wren) h1_compact[h_compact_addr] <= h_compact_dout;
    end

endmodule

//--- verification/tb_privkey_sampler.sv
// Testbench for the private-key sampler with Keccak and memory models
`timescale 1ns/1ps

module tb_privkey_sampler import sampler_pkg::*; ();

    localparam int R_BITS      = 587;
    localparam int WEIGHT      = 10;
    localparam int POS_BITS    = $clog2(R_BITS);
    localparam int ADDR_BITS   = POS_BITS - BIT_SEL_BITS;
    localparam int CNT_BITS    = $clog2(WEIGHT + 1);
    localparam int MEM_WORDS   = 2 ** ADDR_BITS;
    localparam int SEED_INIT   = 32'hce14;
    localparam int DONE_CYCLES = 20000;

    logic                  clk = 1'b0;
    logic                  resetn;
    logic                  enable;
    logic                  done;
    logic [SEED_BITS-1:0]  seed;
    logic                  keccak_enable;
    logic                  keccak_init;
    logic                  keccak_done;
    logic [STATE_BITS-1:0] keccak_m;
    logic [STATE_BITS-1:0] keccak_out;
    logic                  h0_rden;
    logic                  h1_rden;
    logic                  h0_wren;
    logic                  h1_wren;
    logic [ADDR_BITS-1:0]  h_addr;
    logic [WORD_BITS-1:0]  h_dout;
    logic [WORD_BITS-1:0]  h0_din;
    logic [WORD_BITS-1:0]  h1_din;
    logic                  h0_compact_wren;
    logic                  h1_compact_wren;
    logic [CNT_BITS-1:0]   h_compact_addr;
    logic [WORD_BITS-1:0]  h_compact_dout;
    logic                  check_error;
    logic                  any_write;
    logic                  started;
    logic [STATE_BITS-1:0] expected_msg;
    int                    rand_seed = SEED_INIT;
    int                    h0_count = 0;
    int                    h1_count = 0;
    bit                    h1_started = 1'b0;
    int                    obs_pos [$];
    int                    obs_poly [$];

    always #10 clk = ~clk;

    privkey_sampler #(.R_BITS(R_BITS), .WEIGHT(WEIGHT)) uut (.*);

    sampler_env_models #(.R_BITS(R_BITS), .WEIGHT(WEIGHT), .RAND_SEED(SEED_INIT)) env (.*);

    assign any_write = h0_wren | h1_wren | h0_compact_wren | h1_compact_wren;

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        stop_run();
    endtask

    // Seed bytes reversed into the low bits, then the padding bits
    function automatic logic [STATE_BITS-1:0] build_message(input logic [SEED_BITS-1:0] s);
        logic [STATE_BITS-1:0] m;
        int                    i;
        m = '0;
        for (i = 0; i < SEED_BITS / 8; i++) begin
            m[8*i +: 8] = s[SEED_BITS - 1 - 8 * i -: 8];
        end
        m[SEED_BITS +: 5] = 5'b11111;
        m[DIGEST_BITS-1]  = 1'b1;
        return m;
    endfunction

    // Byte 4k of the digest is the low byte of word k
    function automatic logic [WORD_BITS-1:0] digest_word(input logic [DIGEST_BITS-1:0] d,
                                                         input int k);
        logic [WORD_BITS-1:0] word;
        int                   b;
        for (b = 0; b < 4; b++) begin
            word[8*b +: 8] = d[DIGEST_BITS - 1 - 8 * (4 * k + b) -: 8];
        end
        return word;
    endfunction

    // Replays the logged digests and compares positions and memory contents
    function automatic string check_results();
        bit                   taken [R_BITS];
        logic [WORD_BITS-1:0] word;
        int                   pos, w, j, poly, got, ones, p;
        string                err;
        err = "";
        w = 0;
        j = 0;
        for (poly = 0; poly < 2; poly++) begin
            foreach (taken[k]) taken[k] = 1'b0;
            got  = 0;
            ones = 0;
            while (got < WEIGHT && err == "") begin
                if (w >= env.digest_log.size() * DIGEST_WORDS) begin
                    err = "logged digests hold too few usable positions";
                end else begin
                    word = digest_word(env.digest_log[w / DIGEST_WORDS], w % DIGEST_WORDS);
                    pos  = int'(word[POS_BITS-1:0]);
                    w++;
                    if (pos < R_BITS && !taken[pos]) begin
                        taken[pos] = 1'b1;
                        assert (j < obs_pos.size() && obs_pos[j] == pos && obs_poly[j] == poly)
                            else err = $sformatf("h%0d position %0d: expected %0d",
                                                 poly, got, pos);
                        got++;
                        j++;
                    end
                end
            end
            for (p = 0; p < MEM_WORDS; p++) begin
                ones += $countones(poly ? env.h1_mem[p] : env.h0_mem[p]);
            end
            for (p = 0; p < WEIGHT && err == ""; p++) begin
                pos  = int'(poly ? env.h1_compact[p] : env.h0_compact[p]);
                word = poly ? env.h1_mem[pos / 32] : env.h0_mem[pos / 32];
                assert (taken[pos] && word[pos[4:0]])
                    else err = $sformatf("h%0d compact entry %0d holds %0d, not in memory",
                                         poly, p, pos);
            end
            assert (err != "" || ones == WEIGHT)
                else err = $sformatf("h%0d memory holds %0d set bits", poly, ones);
        end
        assert (err != "" || obs_pos.size() == 2 * WEIGHT)
            else err = $sformatf("%0d compact writes seen", obs_pos.size());
        return err;
    endfunction

    // ------------------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------------------
    a_quiet_before_start: assert property (@(posedge clk) disable iff (!resetn)
        !started |-> !(done || keccak_enable || keccak_init || any_write))
        else value_error("outputs active before the start pulse");

    a_quiet_after_done: assert property (@(posedge clk) disable iff (!resetn)
        done |-> !(keccak_enable || keccak_init || any_write) ##1 done)
        else value_error("activity or done drop after completion");

    a_message: assert property (@(posedge clk) disable iff (!resetn)
        keccak_init |-> keccak_m == expected_msg)
        else value_error("absorb message does not match the seed");

    always @(posedge check_error) stop_run();

    // Compact write order and polynomial order
    always @(posedge clk) begin
        if (resetn && h0_wren) begin
            assert (!h1_started) else value_error("h0 word write after h1 writes began");
        end
        if (resetn && h1_wren) begin
            h1_started = 1'b1;
        end
        if (resetn && (h0_compact_wren || h1_compact_wren)) begin
            assert (int'(h_compact_addr) == (h1_compact_wren ? h1_count : h0_count))
                else value_error($sformatf("compact address %0d out of order", h_compact_addr));
            assert (h_compact_dout < R_BITS && (h1_compact_wren ? h1_count : h0_count) < WEIGHT)
                else value_error($sformatf("compact value %0d or count out of range",
                                           h_compact_dout));
            obs_pos.push_back(int'(h_compact_dout));
            obs_poly.push_back(h1_compact_wren ? 1 : 0);
            if (h1_compact_wren) h1_count++;
            else h0_count++;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : run
        int    cycles;
        int    i;
        string err;
        resetn  = 1'b0;
        enable  = 1'b0;
        started = 1'b0;
        for (i = 0; i < SEED_BITS / 32; i++) begin
            seed[32*i +: 32] = $random(rand_seed);
        end
        expected_msg = build_message(seed);
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        // Idle stretch before the start pulse
        repeat (5) @(posedge clk);
        enable  <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: done did not rise within %0d cycles", DONE_CYCLES);
            stop_run();
        end else begin
            repeat (10) @(posedge clk);
            err = check_results();
            if (err != "") begin
                value_error(err);
            end else begin
                $display("Regression passed");
                $finish;
            end
        end
    end

endmodule

//--- filelist.f
src/sampler_pkg.sv
src/sampler_ctrl.sv
src/digest_word_select.sv
src/weight_insert.sv
src/privkey_sampler.sv
verification/sampler_env_models.sv
verification/tb_privkey_sampler.sv

//--- Makefile
# Verilator build and run for the private-key sampler testbench

VERILATOR ?= verilator
TOP       ?= tb_privkey_sampler
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
